// ==== Bender.yml ====
package:
  name: proc

sources:
  - hdl/procPkg.sv
  - hdl/wordMem.sv
  - hdl/fetch.sv
  - hdl/control.sv
  - hdl/decode.sv
  - hdl/execute.sv
  - hdl/proc.sv
  - target: test
    files:
      - dv/procChecker.sv
      - dv/procTb.sv

// ==== dv/procChecker.sv ====
// procChecker: compares every retirement on the trace ports with the expected list
`timescale 1ns/100ps
`default_nettype none

module procChecker import procPkg::*; (
   input wire                     clk,
   input wire                     arstN,
   input wire                     retire,
   input wire [wordWidth-1:0]     pc,
   input wire                     wbEn,
   input wire [regSelWidth-1:0]   wbReg,
   input wire [wordWidth-1:0]     wbData,
   input wire                     halted,
   input wire                     err
);

   string                  testName;
   int                     testErrors;
   // expected retirements in program order
   logic [wordWidth-1:0]   qPc [$];
   logic                   qEn [$];
   logic [regSelWidth-1:0] qReg [$];
   logic [wordWidth-1:0]   qData [$];
   logic                   qErr [$];
   logic                   expEn;
   logic [regSelWidth-1:0] expReg;
   logic [wordWidth-1:0]   expData;
   // state seen at the previous edge
   logic                   prevValid = 1'b0;
   logic                   prevRetire;
   logic                   prevHalted;
   logic [wordWidth-1:0]   prevPc;

   task automatic clearExpected();
      qPc.delete();
      qEn.delete();
      qReg.delete();
      qData.delete();
      qErr.delete();
   endtask

   task automatic startTest(input string name);
      testName   = name;
      testErrors = 0;
      clearExpected();
   endtask

   task automatic expectRetire(input logic [15:0] ePc, input logic eEn, input logic [2:0] eReg,
                               input logic [15:0] eData, input logic eErr);
      qPc.push_back(ePc);
      qEn.push_back(eEn);
      qReg.push_back(eReg);
      qData.push_back(eData);
      qErr.push_back(eErr);
   endtask

   task automatic finishTest(output int errors);
      if (qPc.size() != 0) begin
         $display("%s: %0d expected retirements never happened", testName, qPc.size());
         testErrors++;
      end
      errors = testErrors;
   endtask

   task automatic compareField(input string sig, input logic [15:0] got,
                               input logic [15:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s in %s at pc 0x%h: got 0x%h, expected 0x%h",
                  sig, testName, pc, got, exp);
         testErrors++;
      end
   endtask

   always @(posedge clk) begin
      if (!arstN) begin
         prevValid = 1'b0;
      end else begin
         // a stalled core keeps its pc
         if (prevValid && !prevRetire && pc !== prevPc) begin
            $display("CHECK FAILED pc in %s while stalled: got 0x%h, expected 0x%h",
                     testName, pc, prevPc);
            testErrors++;
         end
         if (retire) begin
            if (qPc.size() == 0) begin
               $display("%s: extra retirement at pc 0x%h", testName, pc);
               testErrors++;
            end else begin
               compareField("pc", pc, qPc.pop_front());
               compareField("err", err, qErr.pop_front());
               expEn   = qEn.pop_front();
               expReg  = qReg.pop_front();
               expData = qData.pop_front();
               compareField("wbEn", wbEn, expEn);
               // register and value only matter for a write
               if (expEn) begin
                  compareField("wbReg", wbReg, expReg);
                  compareField("wbData", wbData, expData);
               end
            end
         end
         if (prevValid && halted && !prevHalted && qPc.size() != 0) begin
            $display("%s: core halted with %0d expected retirements pending",
                     testName, qPc.size());
            testErrors++;
            clearExpected();
         end
         if (prevValid && prevHalted && !halted) begin
            $display("%s: halted dropped without a reset", testName);
            testErrors++;
         end
         prevValid  = 1'b1;
         prevRetire = retire;
         prevHalted = halted;
         prevPc     = pc;
      end
   end

endmodule

`default_nettype wire

// ==== dv/procTb.sv ====
// procTb: loads each program from the table, runs it to halt and prints per-test results
`timescale 1ns/100ps
`default_nettype none

module procTb import procPkg::*; ();

   localparam int numTests   = 4;
   localparam int maxWords   = 16;
   localparam int cycleLimit = 40 * numTests;

   logic                    clk;
   logic                    arstN;
   logic                    run;
   logic                    progWrEn;
   logic [memAddrWidth-1:0] progAddr;
   logic [wordWidth-1:0]    progData;
   logic                    retire;
   logic [wordWidth-1:0]    pc;
   logic                    wbEn;
   logic [regSelWidth-1:0]  wbReg;
   logic [wordWidth-1:0]    wbData;
   logic                    halted;
   logic                    err;

   // program table with one row per test and expectations indexed by word address
   string                   testName [numTests];
   int                      progLen [numTests];
   // cycle count after run rises at which run drops for three cycles or 0 for no pause
   int                      pauseAt [numTests];
   int                      curTest;
   logic [wordWidth-1:0]    progWord [numTests][maxWords];
   logic                    expRetires [numTests][maxWords];
   logic                    expEn [numTests][maxWords];
   logic [regSelWidth-1:0]  expReg [numTests][maxWords];
   logic [wordWidth-1:0]    expData [numTests][maxWords];
   logic                    expErr [numTests][maxWords];

   proc dut0 (
      .clk, .arstN, .run, .progWrEn, .progAddr, .progData,
      .retire, .pc, .wbEn, .wbReg, .wbData, .halted, .err
   );

   procChecker chk0 (
      .clk, .arstN, .retire, .pc, .wbEn, .wbReg, .wbData, .halted, .err
   );

   // instruction encoders built from the isa field positions
   function automatic logic [15:0] iFmt(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] rFmt(input logic [2:0] rs, input logic [2:0] rt,
                                        input logic [2:0] rd, input logic [1:0] fn);
      return {opRType, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] bFmt(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] jFmt(input logic [4:0] op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   // append a word to the current row that retires with the given writeback
   task automatic putWord(input logic [15:0] word, input logic en, input logic [2:0] rg,
                          input logic [15:0] data, input logic er);
      progWord[curTest][progLen[curTest]]   = word;
      expRetires[curTest][progLen[curTest]] = 1'b1;
      expEn[curTest][progLen[curTest]]      = en;
      expReg[curTest][progLen[curTest]]     = rg;
      expData[curTest][progLen[curTest]]    = data;
      expErr[curTest][progLen[curTest]]     = er;
      progLen[curTest]++;
   endtask

   // append a word to the current row that is never reached
   task automatic putSkipped(input logic [15:0] word);
      progWord[curTest][progLen[curTest]]   = word;
      expRetires[curTest][progLen[curTest]] = 1'b0;
      progLen[curTest]++;
   endtask

   task automatic buildTable();
      for (int t = 0; t < numTests; t++) begin
         progLen[t] = 0;
      end
      // immediate and r-format alu with a stall after four retirements
      curTest = 0;
      testName[0] = "alu";
      pauseAt[0] = 4;
      putWord(bFmt(opLbi, 1, 8'h25), 1, 1, 16'h0025, 0);
      putWord(bFmt(opLbi, 2, 8'h9c), 1, 2, 16'hff9c, 0);
      // 0x25 + sext(-3)
      putWord(iFmt(opAddi, 1, 3, 5'h1d), 1, 3, 16'h0022, 0);
      // imm minus rs is 0x0f - 0x25
      putWord(iFmt(opSubi, 1, 4, 5'h0f), 1, 4, 16'hffea, 0);
      // stall lands here so r3 must not step while run is low
      putWord(iFmt(opAddi, 3, 3, 5'h05), 1, 3, 16'h0027, 0);
      // logic immediates are zero extended
      putWord(iFmt(opXori, 2, 5, 5'h1f), 1, 5, 16'hff83, 0);
      putWord(iFmt(opAndni, 2, 6, 5'h14), 1, 6, 16'hff88, 0);
      putWord(rFmt(1, 2, 7, fnAdd), 1, 7, 16'hffc1, 0);
      // rt minus rs
      putWord(rFmt(1, 2, 3, fnSub), 1, 3, 16'hff77, 0);
      putWord(rFmt(1, 2, 4, fnXor), 1, 4, 16'hffb9, 0);
      putWord(rFmt(2, 1, 5, fnAndn), 1, 5, 16'hff98, 0);
      putWord(jFmt(opHalt, 11'h000), 0, 0, 16'h0000, 0);
      // stores and loads at rs + sext(imm5)
      curTest = 1;
      testName[1] = "memory";
      pauseAt[1] = 0;
      putWord(bFmt(opLbi, 1, 8'h10), 1, 1, 16'h0010, 0);
      putWord(bFmt(opLbi, 2, 8'ha5), 1, 2, 16'hffa5, 0);
      // byte 0x14
      putWord(iFmt(opSt, 1, 2, 5'h04), 0, 0, 16'h0000, 0);
      putWord(iFmt(opLd, 1, 3, 5'h04), 1, 3, 16'hffa5, 0);
      putWord(bFmt(opLbi, 4, 8'h3c), 1, 4, 16'h003c, 0);
      // byte 0x0e
      putWord(iFmt(opSt, 1, 4, 5'h1e), 0, 0, 16'h0000, 0);
      putWord(iFmt(opLd, 1, 5, 5'h1e), 1, 5, 16'h003c, 0);
      putWord(iFmt(opLd, 1, 6, 5'h04), 1, 6, 16'hffa5, 0);
      putWord(jFmt(opHalt, 11'h000), 0, 0, 16'h0000, 0);
      // targets are pc + 2 + offset
      curTest = 2;
      testName[2] = "branch";
      pauseAt[2] = 0;
      putWord(bFmt(opLbi, 1, 8'h00), 1, 1, 16'h0000, 0);
      putWord(bFmt(opBeqz, 1, 8'h02), 0, 0, 16'h0000, 0);
      putSkipped(bFmt(opLbi, 2, 8'h11));
      // r1 is zero so bnez falls through
      putWord(bFmt(opBnez, 1, 8'h02), 0, 0, 16'h0000, 0);
      putWord(bFmt(opLbi, 3, 8'h05), 1, 3, 16'h0005, 0);
      putWord(bFmt(opBnez, 3, 8'h02), 0, 0, 16'h0000, 0);
      putSkipped(bFmt(opLbi, 2, 8'h22));
      putWord(jFmt(opJ, 11'h002), 0, 0, 16'h0000, 0);
      putSkipped(bFmt(opLbi, 2, 8'h33));
      // link is the jal pc plus 2
      putWord(jFmt(opJal, 11'h002), 1, 7, 16'h0014, 0);
      putSkipped(bFmt(opLbi, 2, 8'h44));
      putWord(jFmt(opHalt, 11'h000), 0, 0, 16'h0000, 0);
      // bad opcode retires with err and no write and then halts
      curTest = 3;
      testName[3] = "illegal";
      pauseAt[3] = 0;
      putWord(bFmt(opLbi, 1, 8'h7f), 1, 1, 16'h007f, 0);
      putWord(iFmt(opAddi, 1, 2, 5'h01), 1, 2, 16'h0080, 0);
      putWord(jFmt(5'b11111, 11'h0a5), 0, 0, 16'h0000, 1);
      putSkipped(bFmt(opLbi, 4, 8'h12));
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      int                   cyc;
      int                   errs;
      int                   failedTests;
      int                   totalErrs;
      logic [wordWidth-1:0] pcExp;
      arstN       = 1'b0;
      run         = 1'b0;
      progWrEn    = 1'b0;
      progAddr    = '0;
      progData    = '0;
      failedTests = 0;
      totalErrs   = 0;
      buildTable();
      for (int t = 0; t < numTests; t++) begin
         chk0.startTest(testName[t]);
         for (int i = 0; i < progLen[t]; i++) begin
            pcExp = wordWidth'(2 * i);
            if (expRetires[t][i]) begin
               chk0.expectRetire(pcExp, expEn[t][i], expReg[t][i], expData[t][i],
                                 expErr[t][i]);
            end
         end
         @(posedge clk);
         arstN <= 1'b0;
         repeat (2) @(posedge clk);
         arstN <= 1'b1;
         // program load with the core stopped
         for (int i = 0; i < progLen[t]; i++) begin
            @(posedge clk);
            progWrEn <= 1'b1;
            progAddr <= memAddrWidth'(i);
            progData <= progWord[t][i];
         end
         @(posedge clk);
         progWrEn <= 1'b0;
         @(posedge clk);
         run <= 1'b1;
         cyc = 0;
         while (!halted) begin
            @(posedge clk);
            cyc++;
            if (cyc == pauseAt[t]) begin
               run <= 1'b0;
               repeat (3) @(posedge clk);
               run <= 1'b1;
            end
         end
         // run stays high past the halt and nothing more may retire
         repeat (3) @(posedge clk);
         run <= 1'b0;
         @(negedge clk);
         chk0.finishTest(errs);
         totalErrs += errs;
         if (errs == 0) begin
            $display("test %s: ok", testName[t]);
         end else begin
            failedTests++;
            $display("test %s: %0d errors", testName[t], errs);
         end
      end
      $display("tests %0d, failed %0d, errors %0d", numTests, failedTests, totalErrs);
      if (totalErrs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // hang guard sized from the number of tests
   initial begin
      int cycles;
      cycles = 0;
      while (cycles < cycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/control.sv ====
// control: opcode decoder driving the datapath control levels and the illegal-opcode flag
`timescale 1ns/100ps
`default_nettype none

module control import procPkg::*; (
   input  wire [4:0]   opcode,
   output logic        regWrite,
   output logic [1:0]  regDst,
   output logic [1:0]  immSel,
   output logic        aluSrc,
   output logic [1:0]  aluOp,
   output logic        funcUsed,
   output logic        memRead,
   output logic        memWrite,
   output logic        branch,
   output logic        branchOnZero,
   output logic        jump,
   output logic        link,
   output logic        lbi,
   output logic        isHalt,
   output logic        illegal
);

   always_comb begin
      // defaults describe a nop, every write enable off
      regWrite     = 1'b0;
      regDst       = dstBits7to5;
      immSel       = immSext5;
      aluSrc       = 1'b0;
      aluOp        = aluAdd;
      funcUsed     = 1'b0;
      memRead      = 1'b0;
      memWrite     = 1'b0;
      branch       = 1'b0;
      branchOnZero = 1'b0;
      jump         = 1'b0;
      link         = 1'b0;
      lbi          = 1'b0;
      isHalt       = 1'b0;
      illegal      = 1'b0;
      case (opcode)
         opHalt: isHalt = 1'b1;
         opNop: ;
         opAddi, opSubi, opXori, opAndni: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
            // logic ops take an unsigned immediate
            immSel   = opcode[1] ? immZext5 : immSext5;
            // low opcode bits already match the alu encoding
            aluOp    = opcode[1:0];
         end
         opRType: begin
            regWrite = 1'b1;
            regDst   = dstBits4to2;
            funcUsed = 1'b1;
         end
         // st and ld both address at rs + sext(imm5)
         opSt: begin
            aluSrc   = 1'b1;
            memWrite = 1'b1;
         end
         opLd: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
            memRead  = 1'b1;
         end
         opLbi: begin
            regWrite = 1'b1;
            regDst   = dstBits10to8;
            immSel   = immSext8;
            lbi      = 1'b1;
         end
         opBeqz, opBnez: begin
            branch       = 1'b1;
            immSel       = immSext8;
            // beqz is the even one of the pair
            branchOnZero = ~opcode[0];
         end
         opJ: begin
            jump   = 1'b1;
            immSel = immSext11;
         end
         opJal: begin
            jump     = 1'b1;
            immSel   = immSext11;
            link     = 1'b1;
            regWrite = 1'b1;
            regDst   = dstLink;
         end
         // anything else traps, writes stay off from the defaults
         default: illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
// decode: eight-entry register file, write register select and immediate extension
`timescale 1ns/100ps
`default_nettype none

module decode import procPkg::*; (
   input  wire                     clk,
   input  wire                     arstN,
   input  wire [wordWidth-1:0]     instr,
   input  wire [1:0]               regDst,
   input  wire [1:0]               immSel,
   input  wire                     regWrEn,
   input  wire [wordWidth-1:0]     writeData,
   output logic [wordWidth-1:0]    read1Data,
   output logic [wordWidth-1:0]    read2Data,
   output logic [wordWidth-1:0]    immExt,
   output logic [regSelWidth-1:0]  writeReg
);

   logic [wordWidth-1:0] regs [regCount];

   // rs and rt/rd read ports, no write bypass
   assign read1Data = regs[instr[10:8]];
   assign read2Data = regs[instr[7:5]];

   // destination field depends on format
   always_comb begin
      case (regDst)
         dstBits4to2:  writeReg = instr[4:2];
         dstBits7to5:  writeReg = instr[7:5];
         dstBits10to8: writeReg = instr[10:8];
         // jal links through the top register
         default:      writeReg = regSelWidth'(regCount - 1);
      endcase
   end

   always_comb begin
      case (immSel)
         immSext5:  immExt = {{(wordWidth-5){instr[4]}}, instr[4:0]};
         immZext5:  immExt = {{(wordWidth-5){1'b0}}, instr[4:0]};
         immSext8:  immExt = {{(wordWidth-8){instr[7]}}, instr[7:0]};
         // jump displacement
         default:   immExt = {{(wordWidth-11){instr[10]}}, instr[10:0]};
      endcase
   end

   // write lands on the retire edge, readers see it the cycle after
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regs <= '{default: '0};
      end else if (regWrEn) begin
         regs[writeReg] <= writeData;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
// execute: alu, branch test, jump and branch targets, writeback selection
`timescale 1ns/100ps
`default_nettype none

module execute import procPkg::*; (
   input  wire [wordWidth-1:0]   pc,
   input  wire [1:0]             func,
   input  wire [wordWidth-1:0]   read1Data,
   input  wire [wordWidth-1:0]   read2Data,
   input  wire [wordWidth-1:0]   immExt,
   input  wire                   aluSrc,
   input  wire [1:0]             aluOp,
   input  wire                   funcUsed,
   input  wire                   memRead,
   input  wire                   branch,
   input  wire                   branchOnZero,
   input  wire                   jump,
   input  wire                   link,
   input  wire                   lbi,
   input  wire [wordWidth-1:0]   memData,
   output logic [wordWidth-1:0]  dataAddr,
   output logic [wordWidth-1:0]  storeData,
   output logic                  takeTarget,
   output logic [wordWidth-1:0]  target,
   output logic [wordWidth-1:0]  writeData
);

   logic [1:0]           op;
   logic [wordWidth-1:0] opB;
   logic [wordWidth-1:0] aluResult;
   logic [wordWidth-1:0] pcInc;
   logic                 rsZero;

   // r-format picks the operation from its function field
   assign op  = funcUsed ? func : aluOp;
   assign opB = aluSrc ? immExt : read2Data;

   always_comb begin
      aluResult = read1Data + opB;
      case (op)
         aluRsub: aluResult = opB - read1Data;
         aluXor:  aluResult = read1Data ^ opB;
         aluAndn: aluResult = read1Data & ~opB;
         default: ;
      endcase
   end

   assign pcInc = pc + wordWidth'(2);

   // beqz wants rs == 0, bnez wants rs != 0
   assign rsZero     = (read1Data == '0);
   assign takeTarget = jump | (branch & (rsZero == branchOnZero));
   // branches and jumps are both relative to the next pc
   assign target     = pcInc + immExt;

   // st writes rd (second read port) at rs + imm
   assign dataAddr  = aluResult;
   assign storeData = read2Data;

   // link beats load beats lbi beats alu
   always_comb begin
      if (link) begin
         writeData = pcInc;
      end else if (memRead) begin
         writeData = memData;
      end else if (lbi) begin
         writeData = immExt;
      end else begin
         writeData = aluResult;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
// fetch: program counter, next-pc choice, sticky halt and the retire-gated write enables
`timescale 1ns/100ps
`default_nettype none

module fetch import procPkg::*; (
   input  wire                   clk,
   input  wire                   arstN,
   input  wire                   run,
   input  wire                   isHalt,
   input  wire                   illegal,
   input  wire                   regWrite,
   input  wire                   memWrite,
   input  wire                   takeTarget,
   input  wire [wordWidth-1:0]   target,
   output logic [wordWidth-1:0]  pc,
   output logic                  retire,
   output logic                  regWrEn,
   output logic                  dataWrEn,
   output logic                  err,
   output logic                  halted
);

   logic                 stop;
   logic [wordWidth-1:0] pcNext;

   // one instruction retires on every edge while running and not halted
   assign retire = run & ~halted;

   // halt and bad opcodes both freeze the pc and raise halted
   assign stop = isHalt | illegal;

   // taken branch or jump, else sequential byte address
   assign pcNext = takeTarget ? target : pc + wordWidth'(2);

   // no state changes anywhere in the core while stalled
   assign regWrEn  = regWrite & retire;
   assign dataWrEn = memWrite & retire;
   // error reported only for the cycle the bad opcode retires
   assign err      = illegal & retire;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (retire) begin
         if (stop) begin
            halted <= 1'b1;
         end else begin
            pc <= pcNext;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/proc.sv ====
// proc: single-cycle core top, wiring fetch, both memories, control, decode and execute
`timescale 1ns/100ps
`default_nettype none

module proc import procPkg::*; (
   input  wire                     clk,
   input  wire                     arstN,
   input  wire                     run,
   input  wire                     progWrEn,
   input  wire [memAddrWidth-1:0]  progAddr,
   input  wire [wordWidth-1:0]     progData,
   output logic                    retire,
   output logic [wordWidth-1:0]    pc,
   output logic                    wbEn,
   output logic [regSelWidth-1:0]  wbReg,
   output logic [wordWidth-1:0]    wbData,
   output logic                    halted,
   output logic                    err
);

   logic [wordWidth-1:0] instr;
   // control levels
   logic       regWrite, aluSrc, funcUsed, memRead, memWrite;
   logic       branch, branchOnZero, jump, link, lbi, isHalt, illegal;
   logic [1:0] regDst, immSel, aluOp;
   // datapath
   logic [wordWidth-1:0] read1Data, read2Data, immExt, writeData;
   logic [wordWidth-1:0] dataAddr, storeData, memData, target;
   logic                 takeTarget, dataWrEn;

   fetch fetch0 (
      .clk, .arstN, .run, .isHalt, .illegal, .regWrite, .memWrite, .takeTarget, .target,
      .pc, .retire, .regWrEn(wbEn), .dataWrEn, .err, .halted
   );

   // program load only while the core is stopped
   wordMem #(.depth(memDepth)) instMem (
      .clk, .wrEn(progWrEn & ~run), .wrAddr(progAddr), .wrData(progData),
      .rdAddr(pc[memAddrWidth:1]), .rdData(instr)
   );

   control control0 (
      .opcode(instr[15:11]), .regWrite, .regDst, .immSel, .aluSrc, .aluOp, .funcUsed,
      .memRead, .memWrite, .branch, .branchOnZero, .jump, .link, .lbi, .isHalt, .illegal
   );

   decode decode0 (
      .clk, .arstN, .instr, .regDst, .immSel, .regWrEn(wbEn), .writeData,
      .read1Data, .read2Data, .immExt, .writeReg(wbReg)
   );

   execute execute0 (
      .pc, .func(instr[1:0]), .read1Data, .read2Data, .immExt, .aluSrc, .aluOp, .funcUsed,
      .memRead, .branch, .branchOnZero, .jump, .link, .lbi, .memData,
      .dataAddr, .storeData, .takeTarget, .target, .writeData
   );

   // byte addresses, word-indexed storage
   wordMem #(.depth(memDepth)) dataMem (
      .clk, .wrEn(dataWrEn), .wrAddr(dataAddr[memAddrWidth:1]), .wrData(storeData),
      .rdAddr(dataAddr[memAddrWidth:1]), .rdData(memData)
   );

   // trace shows the value written back this cycle
   assign wbData = writeData;

endmodule

`default_nettype wire

// ==== hdl/procPkg.sv ====
// procPkg: widths, opcodes, function codes and control encodings for the 16-bit core
`default_nettype none

package procPkg;

   // datapath and storage sizes
   localparam int wordWidth    = 16;
   localparam int regCount     = 8;
   localparam int regSelWidth  = 3;
   localparam int memDepth     = 256;
   // word index into either memory, taken from byte address bits 8..1
   localparam int memAddrWidth = 8;

   // primary opcodes, instr[15:11]
   localparam logic [4:0] opHalt  = 5'b00000;
   localparam logic [4:0] opNop   = 5'b00001;
   localparam logic [4:0] opJ     = 5'b00100;
   localparam logic [4:0] opJal   = 5'b00110;
   // immediate alu group, low two bits line up with the alu op codes
   localparam logic [4:0] opAddi  = 5'b01000;
   localparam logic [4:0] opSubi  = 5'b01001;
   localparam logic [4:0] opXori  = 5'b01010;
   localparam logic [4:0] opAndni = 5'b01011;
   // branches on rs against zero
   localparam logic [4:0] opBeqz  = 5'b01100;
   localparam logic [4:0] opBnez  = 5'b01101;
   // memory and load-immediate
   localparam logic [4:0] opSt    = 5'b10000;
   localparam logic [4:0] opLd    = 5'b10001;
   localparam logic [4:0] opLbi   = 5'b11000;
   // register-register alu, operation in instr[1:0]
   localparam logic [4:0] opRType = 5'b11011;

   // r-format function codes
   localparam logic [1:0] fnAdd  = 2'b00;
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnXor  = 2'b10;
   localparam logic [1:0] fnAndn = 2'b11;

   // alu operations, same encoding as the function codes
   localparam logic [1:0] aluAdd  = fnAdd;
   // second operand minus first
   localparam logic [1:0] aluRsub = fnSub;
   localparam logic [1:0] aluXor  = fnXor;
   // first operand and not second
   localparam logic [1:0] aluAndn = fnAndn;

   // immediate extension selects
   localparam logic [1:0] immSext5  = 2'b00;
   localparam logic [1:0] immZext5  = 2'b01;
   localparam logic [1:0] immSext8  = 2'b10;
   localparam logic [1:0] immSext11 = 2'b11;

   // write register selects
   localparam logic [1:0] dstBits4to2  = 2'b00;
   localparam logic [1:0] dstBits7to5  = 2'b01;
   localparam logic [1:0] dstBits10to8 = 2'b10;
   localparam logic [1:0] dstLink      = 2'b11;

endpackage

`default_nettype wire

// ==== hdl/wordMem.sv ====
// wordMem: word RAM with combinational read and clocked write, for instructions and data
`timescale 1ns/100ps
`default_nettype none

module wordMem import procPkg::*; #(
   parameter int depth = memDepth
) (
   input  wire                       clk,
   input  wire                       wrEn,
   input  wire [$clog2(depth)-1:0]   wrAddr,
   input  wire [wordWidth-1:0]       wrData,
   input  wire [$clog2(depth)-1:0]   rdAddr,
   output logic [wordWidth-1:0]      rdData
);

   // storage only, contents are undefined until written
   logic [wordWidth-1:0] mem [depth];

   // read path is a plain mux so a load completes in its own cycle
   assign rdData = mem[rdAddr];

   // single write port
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
   end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/procPkg.sv
hdl/wordMem.sv
hdl/fetch.sv
hdl/control.sv
hdl/decode.sv
hdl/execute.sv
hdl/proc.sv
dv/procChecker.sv
dv/procTb.sv
